//--- mm_ram_golden.txt
# name op addr be data expected
# W write, R read, I fetch, N idle for data cycles, A irq ack with id data, E output addr level
be_init    W 00000100 f 11223344 0
be_lo      W 00000100 1 000000aa 0
be_hi      W 00000100 c bbcc0000 0
be_rd      R 00000100 0 00000000 bbcc33aa
b2b_w      W 00000104 f 1a1b1c1d 0
b2b_r0     R 00000104 0 00000000 1a1b1c1d
b2b_r1     R 00000100 0 00000000 bbcc33aa
if_w0      W 00000300 f 00000013 0
if_w1      W 00000304 f 00100093 0
if_w2      W 00000308 f 00200113 0
if_w3      W 0000030c f 00308193 0
if_line    I 00000308 0 00000000 00308193002001130010009300000013
pass_wr    W 20000000 f 075bcd15 0
pass_n1    N 00000000 0 00000001 0
pass_hi    E 00000001 0 00000000 1
pass_n2    N 00000000 0 00000001 0
pass_lo    E 00000001 0 00000000 0
fail_wr    W 20000000 f 00000001 0
fail_n1    N 00000000 0 00000001 0
fail_hi    E 00000002 0 00000000 1
fail_n2    N 00000000 0 00000001 0
fail_lo    E 00000002 0 00000000 0
other_wr   W 20000000 f 00000005 0
other_n1   N 00000000 0 00000001 0
other_p    E 00000001 0 00000000 0
other_f    E 00000002 0 00000000 0
exit_wr    W 20000004 f 0000002a 0
exit_n1    N 00000000 0 00000001 0
exit_vld   E 00000003 0 00000000 1
exit_val   E 00000004 0 00000000 2a
tmr_mask   W 15000000 f 00000080 0
tmr_cnt    W 15000004 f 00000003 0
tmr_wait   N 00000000 0 00000003 0
tmr_pre    E 00000000 0 00000000 0
tmr_n1     N 00000000 0 00000001 0
tmr_rise   E 00000000 0 00000000 1
tmr_n2     N 00000000 0 00000002 0
tmr_hold   E 00000000 0 00000000 1
tmr_ack    A 00000000 0 00000007 0
tmr_n3     N 00000000 0 00000001 0
tmr_clr    E 00000000 0 00000000 0
off_mask   W 15000000 f 00000000 0
off_cnt    W 15000004 f 00000002 0
off_wait   N 00000000 0 00000004 0
off_lo     E 00000000 0 00000000 0
um_rd      R 30000000 0 00000000 0
um_wr      W 00010100 f ffffffff 0
um_chk     R 00000100 0 00000000 bbcc33aa

//--- sources.f
mm_ram_pkg.sv
dp_ram.sv
sim_ctrl.sv
data_router.sv
mm_ram.sv
tb_mm_ram.sv

//--- Makefile
TOP := tb_mm_ram

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module $(TOP) -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

//--- tb_mm_ram.sv
// RAM wrapper testbench

`timescale 1ns/100ps

module tb_mm_ram;

    logic         clk_i;
    logic         rst_ni;
    logic         instr_req_i;
    logic [15:0]  instr_addr_i;
    logic         instr_gnt_o;
    logic         instr_rvalid_o;
    logic [127:0] instr_rdata_o;
    logic         data_req_i;
    logic [31:0]  data_addr_i;
    logic         data_we_i;
    logic [3:0]   data_be_i;
    logic [31:0]  data_wdata_i;
    logic         data_gnt_o;
    logic         data_rvalid_o;
    logic [31:0]  data_rdata_o;
    logic         irq_ack_i;
    logic [4:0]   irq_id_i;
    logic         irq_timer_o;
    logic         tests_passed_o;
    logic         tests_failed_o;
    logic         exit_valid_o;
    logic [31:0]  exit_value_o;

    // one golden operation per entry
    string        names[$];
    string        ops[$];
    logic [31:0]  addrs[$];
    logic [3:0]   bes[$];
    logic [31:0]  datas[$];
    logic [127:0] exps[$];

    // responses due at the next falling edge
    logic         data_pend;
    logic [31:0]  data_exp;
    string        data_name;
    logic         instr_pend;
    logic [127:0] instr_exp;
    string        instr_name;

    int           cycles = 0;
    int           cycle_limit = 100;

    mm_ram dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in test %s: expected %0h, actual %0h", name, expected, actual);
            abort_run("stopping at the first mismatch");
        end
    endtask

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            abort_run($sformatf("Timeout: operations did not finish in %0d cycles", cycle_limit));
        end
    end

    task automatic load_golden();
        int           fd;
        int           n;
        string        tok;
        string        op;
        logic [1023:0] rest;
        logic [31:0]  addr;
        logic [3:0]   be;
        logic [31:0]  data;
        logic [127:0] exp;
        fd = $fopen("mm_ram_golden.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the golden file mm_ram_golden.txt");
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok[0] == "#") begin
                n = $fgets(rest, fd);
            end else begin
                n = $fscanf(fd, "%s %h %h %h %h", op, addr, be, data, exp);
                if (n != 5) begin
                    abort_run({"Golden file line for ", tok, " is incomplete"});
                end
                names.push_back(tok);
                ops.push_back(op);
                addrs.push_back(addr);
                bes.push_back(be);
                datas.push_back(data);
                exps.push_back(exp);
            end
        end
        $fclose(fd);
    endtask

    // step to the next falling edge, check what is due there, then go idle
    task automatic next_cycle();
        @(negedge clk_i);
        check({data_name, " gnt"}, data_pend, data_gnt_o);
        check({data_name, " rvalid"}, data_pend, data_rvalid_o);
        if (data_pend) begin
            check({data_name, " rdata"}, data_exp, data_rdata_o);
        end
        check({instr_name, " gnt"}, instr_pend, instr_gnt_o);
        check({instr_name, " rvalid"}, instr_pend, instr_rvalid_o);
        if (instr_pend) begin
            check({instr_name, " line"}, instr_exp, instr_rdata_o);
        end
        data_pend   = 1'b0;
        instr_pend  = 1'b0;
        data_req_i  = 1'b0;
        data_we_i   = 1'b0;
        instr_req_i = 1'b0;
        irq_ack_i   = 1'b0;
    endtask

    // output picked by the address column of an E line
    function automatic logic [127:0] output_level(input logic [31:0] sel);
        case (sel)
            0: return irq_timer_o;
            1: return tests_passed_o;
            2: return tests_failed_o;
            3: return exit_valid_o;
            4: return exit_value_o;
            default: return '1;
        endcase
    endfunction

    task automatic run_op(input int i);
        if (ops[i] == "W" || ops[i] == "R") begin
            next_cycle();
            data_req_i   = 1'b1;
            data_we_i    = (ops[i] == "W");
            data_addr_i  = addrs[i];
            data_be_i    = bes[i];
            data_wdata_i = datas[i];
            data_pend    = 1'b1;
            data_name    = names[i];
            // writes answer with zero data
            data_exp     = (ops[i] == "W") ? 32'h0 : exps[i][31:0];
        end else if (ops[i] == "I") begin
            next_cycle();
            instr_req_i  = 1'b1;
            instr_addr_i = addrs[i][15:0];
            instr_pend   = 1'b1;
            instr_name   = names[i];
            instr_exp    = exps[i];
        end else if (ops[i] == "N") begin
            repeat (datas[i]) next_cycle();
        end else if (ops[i] == "A") begin
            next_cycle();
            irq_ack_i = 1'b1;
            irq_id_i  = datas[i][4:0];
        end else if (ops[i] == "E") begin
            check(names[i], exps[i], output_level(addrs[i]));
        end else begin
            abort_run({"Unknown operation ", ops[i], " in golden line ", names[i]});
        end
    endtask

    initial begin
        rst_ni       = 1'b0;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_addr_i  = '0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_wdata_i = '0;
        irq_ack_i    = 1'b0;
        irq_id_i     = '0;
        data_pend    = 1'b0;
        instr_pend   = 1'b0;
        data_name    = "reset";
        instr_name   = "reset";
        load_golden();
        cycle_limit = 20 * names.size() + 100;
        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;
        // all response and event outputs quiet out of reset
        check("reset", '0, {data_rvalid_o, instr_rvalid_o, irq_timer_o,
                            tests_passed_o, tests_failed_o, exit_valid_o});
        foreach (names[i]) begin
            run_op(i);
        end
        next_cycle();
        // pulses have ended and the masked timer stayed quiet
        check("end", '0, {irq_timer_o, tests_passed_o, tests_failed_o, exit_valid_o});
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- mm_ram.sv
// Memory-mapped RAM top level

`timescale 1ns/100ps

module mm_ram import mm_ram_pkg::*; #(
    parameter int RAM_ADDR_WIDTH    = 16,
    parameter int INSTR_RDATA_WIDTH = 128
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,

    // instruction port
    input  logic                         instr_req_i,
    input  logic [RAM_ADDR_WIDTH-1:0]    instr_addr_i,
    output logic                         instr_gnt_o,
    output logic                         instr_rvalid_o,
    output logic [INSTR_RDATA_WIDTH-1:0] instr_rdata_o,

    // data port
    input  logic                         data_req_i,
    input  logic [ADDR_W-1:0]            data_addr_i,
    input  logic                         data_we_i,
    input  logic [BE_W-1:0]              data_be_i,
    input  logic [DATA_W-1:0]            data_wdata_i,
    output logic                         data_gnt_o,
    output logic                         data_rvalid_o,
    output logic [DATA_W-1:0]            data_rdata_o,

    // interrupt
    input  logic                         irq_ack_i,
    input  logic [4:0]                   irq_id_i,
    output logic                         irq_timer_o,

    // test status
    output logic                         tests_passed_o,
    output logic                         tests_failed_o,
    output logic                         exit_valid_o,
    output logic [DATA_W-1:0]            exit_value_o
);

    // router to RAM
    logic                      ram_req;
    logic [RAM_ADDR_WIDTH-1:0] ram_addr;
    logic                      ram_we;
    logic [BE_W-1:0]           ram_be;
    logic [DATA_W-1:0]         ram_wdata;
    logic [DATA_W-1:0]         ram_rdata;

    // router to control block
    logic                      ctrl_we;
    logic [ADDR_W-1:0]         ctrl_addr;
    logic [DATA_W-1:0]         ctrl_wdata;

    data_router #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) data_router_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .data_req_i     (data_req_i),
        .data_addr_i    (data_addr_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .ram_req_o      (ram_req),
        .ram_addr_o     (ram_addr),
        .ram_we_o       (ram_we),
        .ram_be_o       (ram_be),
        .ram_wdata_o    (ram_wdata),
        .ram_rdata_i    (ram_rdata),
        .ctrl_we_o      (ctrl_we),
        .ctrl_addr_o    (ctrl_addr),
        .ctrl_wdata_o   (ctrl_wdata)
    );

    dp_ram #(
        .RAM_ADDR_WIDTH    (RAM_ADDR_WIDTH),
        .INSTR_RDATA_WIDTH (INSTR_RDATA_WIDTH)
    ) dp_ram_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_req_i     (ram_req),
        .data_addr_i    (ram_addr),
        .data_we_i      (ram_we),
        .data_be_i      (ram_be),
        .data_wdata_i   (ram_wdata),
        .data_rdata_o   (ram_rdata)
    );

    sim_ctrl sim_ctrl_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .ctrl_we_i      (ctrl_we),
        .ctrl_addr_i    (ctrl_addr),
        .ctrl_wdata_i   (ctrl_wdata),
        .irq_ack_i      (irq_ack_i),
        .irq_id_i       (irq_id_i),
        .irq_timer_o    (irq_timer_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

endmodule

//--- data_router.sv
// Data port address router

`timescale 1ns/100ps

module data_router import mm_ram_pkg::*; #(
    parameter int RAM_ADDR_WIDTH = 16
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    // data port from the core
    input  logic                      data_req_i,
    input  logic [ADDR_W-1:0]         data_addr_i,
    input  logic                      data_we_i,
    input  logic [BE_W-1:0]           data_be_i,
    input  logic [DATA_W-1:0]         data_wdata_i,
    output logic                      data_gnt_o,
    output logic                      data_rvalid_o,
    output logic [DATA_W-1:0]         data_rdata_o,

    // RAM data port
    output logic                      ram_req_o,
    output logic [RAM_ADDR_WIDTH-1:0] ram_addr_o,
    output logic                      ram_we_o,
    output logic [BE_W-1:0]           ram_be_o,
    output logic [DATA_W-1:0]         ram_wdata_o,
    input  logic [DATA_W-1:0]         ram_rdata_i,

    // control block
    output logic                      ctrl_we_o,
    output logic [ADDR_W-1:0]         ctrl_addr_o,
    output logic [DATA_W-1:0]         ctrl_wdata_o
);

    data_target_e target;
    data_target_e target_q;
    logic         we_q;

    // address decode
    always_comb begin
        if ((data_addr_i >> RAM_ADDR_WIDTH) == '0) begin
            target = TGT_RAM;
        end else if (data_addr_i == TIMER_MASK_ADDR || data_addr_i == TIMER_CNT_ADDR ||
                     data_addr_i == TEST_STATUS_ADDR || data_addr_i == EXIT_ADDR) begin
            target = TGT_CTRL;
        end else begin
            target = TGT_NONE;
        end
    end

    // no wait states on this port
    assign data_gnt_o = data_req_i;

    // steering to the RAM
    assign ram_req_o   = data_req_i && (target == TGT_RAM);
    assign ram_addr_o  = data_addr_i[RAM_ADDR_WIDTH-1:0];
    assign ram_we_o    = data_we_i;
    assign ram_be_o    = data_be_i;
    assign ram_wdata_o = data_wdata_i;

    // control registers only see writes
    assign ctrl_we_o    = data_req_i && data_we_i && (target == TGT_CTRL);
    assign ctrl_addr_o  = data_addr_i;
    assign ctrl_wdata_o = data_wdata_i;

    // every request completes on the next cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            data_rvalid_o <= 1'b0;
            target_q      <= TGT_NONE;
            we_q          <= 1'b0;
        end else begin
            data_rvalid_o <= data_req_i;
            target_q      <= data_req_i ? target : TGT_NONE;
            we_q          <= data_we_i;
        end
    end

    // only RAM reads return data
    assign data_rdata_o = (target_q == TGT_RAM && !we_q) ? ram_rdata_i : '0;

endmodule

//--- sim_ctrl.sv
// Simulation control block

`timescale 1ns/100ps

module sim_ctrl import mm_ram_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,

    // register writes from the data router
    input  logic              ctrl_we_i,
    input  logic [ADDR_W-1:0] ctrl_addr_i,
    input  logic [DATA_W-1:0] ctrl_wdata_i,

    // interrupt acknowledge from the core
    input  logic              irq_ack_i,
    input  logic [4:0]        irq_id_i,

    output logic              irq_timer_o,
    output logic              tests_passed_o,
    output logic              tests_failed_o,
    output logic              exit_valid_o,
    output logic [DATA_W-1:0] exit_value_o
);

    logic              mask_we;
    logic              cnt_we;
    logic              status_we;
    logic              exit_we;
    logic              timer_we;
    logic              timer_ack;

    logic              timer_en_q;
    logic [DATA_W-1:0] timer_cnt_q;

    // register select
    always_comb begin
        mask_we   = 1'b0;
        cnt_we    = 1'b0;
        status_we = 1'b0;
        exit_we   = 1'b0;
        if (ctrl_we_i) begin
            case (ctrl_addr_i)
                TIMER_MASK_ADDR:  mask_we   = 1'b1;
                TIMER_CNT_ADDR:   cnt_we    = 1'b1;
                TEST_STATUS_ADDR: status_we = 1'b1;
                EXIT_ADDR:        exit_we   = 1'b1;
                default: ;
            endcase
        end
    end

    // either timer register being written holds the countdown for that cycle
    assign timer_we  = mask_we || cnt_we;
    assign timer_ack = irq_ack_i && (irq_id_i == TIMER_IRQ_ID);

    // single-cycle status and exit pulses
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
        end else begin
            tests_passed_o <= status_we && (ctrl_wdata_i == TEST_PASS_CODE);
            tests_failed_o <= status_we && (ctrl_wdata_i == TEST_FAIL_CODE);
            exit_valid_o   <= exit_we;
        end
    end

    // exit value register loaded by each exit write
    always_ff @(posedge clk_i) begin
        if (exit_we) begin
            exit_value_o <= ctrl_wdata_i;
        end
    end

    // countdown timer
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            timer_en_q  <= 1'b0;
            timer_cnt_q <= '0;
            irq_timer_o <= 1'b0;
        end else begin
            if (mask_we) begin
                timer_en_q <= ctrl_wdata_i[TIMER_IRQ_ID];
            end

            if (cnt_we) begin
                timer_cnt_q <= ctrl_wdata_i;
            end else if (!timer_we && timer_cnt_q != '0) begin
                timer_cnt_q <= timer_cnt_q - 1'b1;
            end

            // fire on the step from 1 to 0
            // an ack wins over a new expiry
            if (timer_ack) begin
                irq_timer_o <= 1'b0;
            end else if (!timer_we && timer_cnt_q == DATA_W'(1) && timer_en_q) begin
                irq_timer_o <= 1'b1;
            end
        end
    end

endmodule

//--- dp_ram.sv
// Dual-port RAM

`timescale 1ns/100ps

module dp_ram import mm_ram_pkg::*; #(
    parameter int RAM_ADDR_WIDTH    = 16,
    parameter int INSTR_RDATA_WIDTH = 128
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,

    // instruction fetch port
    input  logic                         instr_req_i,
    input  logic [RAM_ADDR_WIDTH-1:0]    instr_addr_i,
    output logic                         instr_gnt_o,
    output logic                         instr_rvalid_o,
    output logic [INSTR_RDATA_WIDTH-1:0] instr_rdata_o,

    // data port
    input  logic                         data_req_i,
    input  logic [RAM_ADDR_WIDTH-1:0]    data_addr_i,
    input  logic                         data_we_i,
    input  logic [BE_W-1:0]              data_be_i,
    input  logic [DATA_W-1:0]            data_wdata_i,
    output logic [DATA_W-1:0]            data_rdata_o
);

    localparam int WORD_AW    = RAM_ADDR_WIDTH - 2;
    localparam int NUM_WORDS  = 2 ** WORD_AW;
    localparam int LINE_WORDS = INSTR_RDATA_WIDTH / DATA_W;

    // storage is organised as 32-bit words
    logic [DATA_W-1:0]  mem [NUM_WORDS];

    logic [WORD_AW-1:0] data_word_idx;
    logic [WORD_AW-1:0] instr_word_base;

    assign data_word_idx = data_addr_i[RAM_ADDR_WIDTH-1:2];

    // first word of the line with the fetch address aligned down to the line size
    assign instr_word_base = instr_addr_i[RAM_ADDR_WIDTH-1:2] & ~WORD_AW'(LINE_WORDS - 1);

    // fetches are always accepted
    assign instr_gnt_o = instr_req_i;

    // byte-enabled write or word read on the data port
    always_ff @(posedge clk_i) begin
        if (data_req_i) begin
            if (data_we_i) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (data_be_i[b]) begin
                        mem[data_word_idx][8*b +: 8] <= data_wdata_i[8*b +: 8];
                    end
                end
            end else begin
                data_rdata_o <= mem[data_word_idx];
            end
        end
    end

    // lowest address goes to the lowest bits of the instruction line
    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            for (int k = 0; k < LINE_WORDS; k++) begin
                instr_rdata_o[DATA_W*k +: DATA_W] <= mem[instr_word_base + WORD_AW'(k)];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_o <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
        end
    end

endmodule

//--- mm_ram_pkg.sv
// RAM wrapper shared definitions

package mm_ram_pkg;

    // data port widths
    localparam int DATA_W = 32;
    localparam int BE_W   = DATA_W / 8;
    localparam int ADDR_W = 32;

    // control region
    localparam logic [ADDR_W-1:0] CTRL_BASE = 32'h1500_0000;

    // timer registers sit at the start of the control region
    localparam logic [ADDR_W-1:0] TIMER_MASK_ADDR  = CTRL_BASE;
    localparam logic [ADDR_W-1:0] TIMER_CNT_ADDR   = CTRL_BASE + 32'h4;

    // test status and exit report
    localparam logic [ADDR_W-1:0] TEST_STATUS_ADDR = 32'h2000_0000;
    localparam logic [ADDR_W-1:0] EXIT_ADDR        = 32'h2000_0004;

    // values the software writes to the status register
    localparam logic [DATA_W-1:0] TEST_PASS_CODE = 32'd123456789;
    localparam logic [DATA_W-1:0] TEST_FAIL_CODE = 32'd1;

    // timer interrupt id and enable bit position in the mask register
    localparam logic [4:0] TIMER_IRQ_ID = 5'd7;

    // where an accepted data request was steered
    typedef enum logic [1:0] {
        TGT_RAM,
        TGT_CTRL,
        TGT_NONE
    } data_target_e;

endpackage
